// File: design/mm_pkg.sv
// ##########################################################
// Matrix-multiply tile package
// Sizes, Q8.8 constants and the packed chunk and flag types
// ##########################################################
`default_nettype none

package mm_pkg;

    // Operand format, signed Q8.8
    localparam int DATA_W = 16;
    localparam int FRAC_W = 8;

    // Tile geometry
    localparam int CHUNK     = 4;
    localparam int NUM_CORES = 4;
    localparam int INNER_DIM = 64;
    localparam int BEATS     = INNER_DIM / NUM_CORES;

    // Accumulation never overflows at this depth
    localparam int ACC_W = 32;
    localparam int CNT_W = 5;

    // Cross-core sum needs log2(NUM_CORES) extra bits
    localparam int SUM_W = ACC_W + $clog2(NUM_CORES);

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    // Saturation bounds of one output word
    localparam data_t DATA_MAX = data_t'((2 ** (DATA_W - 1)) - 1);
    localparam data_t DATA_MIN = data_t'(-(2 ** (DATA_W - 1)));

    typedef data_t  [CHUNK-1:0]     chunk_t;
    typedef acc_t   [CHUNK-1:0]     acc_chunk_t;
    typedef chunk_t [NUM_CORES-1:0] weight_bus_t;

    typedef struct packed {
        logic systolic_finish;
        logic accumulator_done;
    } core_flags_t;

endpackage

`default_nettype wire

// File: design/mac_lane.sv
// ##########################################################
// Two-stage multiply, shift and accumulate lane
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module mac_lane
    import mm_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  clear,
    input  logic  take,
    input  data_t a,
    input  data_t b,
    output acc_t  acc
);

    logic signed [2*DATA_W-1:0] product;
    acc_t                       prod_q;
    logic                       valid_q;
    acc_t                       acc_q;

    // Full product, then drop the fraction bits
    assign product = a * b;

    // Stage 1 payload
    always_ff @(posedge clk) begin
        if (clear) begin
            prod_q <= '0;
        end else if (take) begin
            prod_q <= acc_t'(product >>> FRAC_W);
        end
    end

    // Stage 1 valid bit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (clear) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= take;
        end
    end

    // Stage 2 accumulate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (clear) begin
            acc_q <= '0;
        end else if (valid_q) begin
            acc_q <= acc_q + prod_q;
        end
    end

    assign acc = acc_q;

endmodule

`default_nettype wire

// File: design/dot_core.sv
// ##########################################################
// Dot-product core
// Counts beats, drives CHUNK MAC lanes, raises finish flags
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module dot_core
    import mm_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        reset_acc,
    input  chunk_t      input_n,
    input  chunk_t      input_w,
    output acc_chunk_t  result,
    output core_flags_t flags
);

    logic [CNT_W-1:0] count_q;
    logic             take;
    logic             finish_q;
    logic             done_q;

    // Beats past BEATS are ignored until reset_acc
    assign take = en && (count_q < CNT_W'(BEATS)) && !reset_acc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (reset_acc) begin
            count_q <= '0;
        end else if (take) begin
            count_q <= count_q + 1'b1;
        end
    end

    // Finish one cycle after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            finish_q <= 1'b0;
        end else if (reset_acc) begin
            finish_q <= 1'b0;
        end else begin
            finish_q <= (count_q == CNT_W'(BEATS));
        end
    end

    // Done trails finish by the lane's add stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else if (reset_acc) begin
            done_q <= 1'b0;
        end else begin
            done_q <= finish_q;
        end
    end

    assign flags.systolic_finish  = finish_q;
    assign flags.accumulator_done = done_q;

    // One lane per chunk element
    for (genvar j = 0; j < CHUNK; j++) begin : g_lane
        mac_lane lane_i (
            .clk   (clk),
            .rst_n (rst_n),
            .clear (reset_acc),
            .take  (take),
            .a     (input_n[j]),
            .b     (input_w[j]),
            .acc   (result[j])
        );
    end

endmodule

`default_nettype wire

// File: design/reduce_buffer.sv
// ##########################################################
// Result buffer
// Sums core results per lane, saturates, holds output chunk
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module reduce_buffer
    import mm_pkg::*;
(
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        all_done,
    input  acc_chunk_t [NUM_CORES-1:0]  core_results,
    output chunk_t                      out_top,
    output logic                        out_valid
);

    chunk_t sat_chunk;
    logic   done_q;
    logic   capture;
    chunk_t out_q;
    logic   valid_q;

    // Per-lane cross-core sum and clamp
    always_comb begin
        logic signed [SUM_W-1:0] sum;
        acc_t                    part;
        for (int j = 0; j < CHUNK; j++) begin
            sum = '0;
            for (int c = 0; c < NUM_CORES; c++) begin
                part = core_results[c][j];
                sum  = sum + SUM_W'(part);
            end
            if (sum > DATA_MAX) begin
                sat_chunk[j] = DATA_MAX;
            end else if (sum < DATA_MIN) begin
                sat_chunk[j] = DATA_MIN;
            end else begin
                sat_chunk[j] = data_t'(sum);
            end
        end
    end

    // Capture only on the first cycle of all_done
    assign capture = all_done && !done_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            done_q <= all_done;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= capture;
            if (capture) begin
                out_q <= sat_chunk;
            end
        end
    end

    assign out_top   = out_q;
    assign out_valid = valid_q;

endmodule

`default_nettype wire

// File: design/mm_top.sv
// ##########################################################
// Matrix-multiply tile top level
// Four dot-product cores feeding one reduction buffer
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module mm_top
    import mm_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        en,
    input  logic        reset_acc,
    input  chunk_t      input_n,
    input  weight_bus_t input_w,
    output chunk_t      out_top,
    output logic        out_valid,
    output logic        systolic_finish,
    output logic        accumulator_done
);

    acc_chunk_t  [NUM_CORES-1:0] core_results;
    core_flags_t [NUM_CORES-1:0] core_flags;
    logic        [NUM_CORES-1:0] finish_vec;
    logic        [NUM_CORES-1:0] done_vec;

    // Activations shared, weights sliced per core
    for (genvar c = 0; c < NUM_CORES; c++) begin : g_core
        dot_core core_i (
            .clk       (clk),
            .rst_n     (rst_n),
            .en        (en),
            .reset_acc (reset_acc),
            .input_n   (input_n),
            .input_w   (input_w[c]),
            .result    (core_results[c]),
            .flags     (core_flags[c])
        );

        assign finish_vec[c] = core_flags[c].systolic_finish;
        assign done_vec[c]   = core_flags[c].accumulator_done;
    end

    assign systolic_finish  = &finish_vec;
    assign accumulator_done = &done_vec;

    reduce_buffer buffer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .all_done     (accumulator_done),
        .core_results (core_results),
        .out_top      (out_top),
        .out_valid    (out_valid)
    );

endmodule

`default_nettype wire

// File: sim/tb_clock.sv
// ##########################################################
// Testbench clock generator, 40 ns period
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk
);

    localparam int HALF_PERIOD_NS = 20;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

`default_nettype wire

// File: sim/mm_tb.sv
// ##########################################################
// Matrix-multiply tile testbench
// Random tiles checked against a Q8.8 reference model
// ##########################################################
`timescale 1ns/1ps
`default_nettype none

module mm_tb
    import mm_pkg::*;
();

    localparam int NUM_TILES   = 9;
    localparam int POST_CYCLES = 8;
    localparam int SMALL_RANGE = 512;
    localparam int TILE_CYCLES = 80;

    logic        clk;
    logic        rst_n;
    logic        en;
    logic        reset_acc;
    chunk_t      input_n;
    weight_bus_t input_w;
    chunk_t      out_top;
    logic        out_valid;
    logic        systolic_finish;
    logic        accumulator_done;

    integer seed;
    int     errors;
    int     checks;

    tb_clock clock_i (
        .clk (clk)
    );

    mm_top mm_top_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .en               (en),
        .reset_acc        (reset_acc),
        .input_n          (input_n),
        .input_w          (input_w),
        .out_top          (out_top),
        .out_valid        (out_valid),
        .systolic_finish  (systolic_finish),
        .accumulator_done (accumulator_done)
    );

    // Small operands stay within about +-2.0
    function automatic data_t rand_word(input bit big);
        if (big) begin
            return data_t'($random(seed));
        end
        return data_t'($random(seed) % SMALL_RANGE);
    endfunction

    // Q8.8 product with the fraction bits dropped
    function automatic longint shifted_product(input data_t a, input data_t b);
        longint p;
        p = longint'(a) * longint'(b);
        return p >>> FRAC_W;
    endfunction

    function automatic data_t clamp_word(input longint value);
        if (value > 32767) begin
            return 16'sh7fff;
        end
        if (value < -32768) begin
            return 16'sh8000;
        end
        return data_t'(value);
    endfunction

    task automatic check_outputs(input logic finish_exp, input logic done_exp,
                                 input logic valid_exp, input chunk_t out_exp,
                                 input string phase);
        checks += 3;
        if (systolic_finish !== finish_exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: systolic_finish is %b, expected %b",
                     $time, phase, systolic_finish, finish_exp);
        end
        if (accumulator_done !== done_exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: accumulator_done is %b, expected %b",
                     $time, phase, accumulator_done, done_exp);
        end
        if (out_valid !== valid_exp) begin
            errors++;
            $display("[FAIL] t=%0t %s: out_valid is %b, expected %b",
                     $time, phase, out_valid, valid_exp);
        end
        for (int j = 0; j < CHUNK; j++) begin
            checks++;
            if (out_top[j] !== out_exp[j]) begin
                errors++;
                $display("[FAIL] t=%0t %s: out_top lane %0d is %0d, expected %0d",
                         $time, phase, j, out_top[j], out_exp[j]);
            end
        end
    endtask

    // One cycle of stimulus, en low on about a third of the cycles
    task automatic drive_beat(input bit big, input bit force_en, output bit taken);
        en = force_en || (($unsigned($random(seed)) % 3) != 0);
        for (int j = 0; j < CHUNK; j++) begin
            input_n[j] = rand_word(big);
            for (int c = 0; c < NUM_CORES; c++) begin
                input_w[c][j] = rand_word(big);
            end
        end
        taken = en;
    endtask

    // reset_acc wins over en in the same cycle
    task automatic clear_tile();
        chunk_t held;
        bit     unused_take;
        held = out_top;
        drive_beat(1'b0, 1'b1, unused_take);
        reset_acc = 1'b1;
        @(negedge clk);
        reset_acc = 1'b0;
        check_outputs(1'b0, 1'b0, 1'b0, held, "after reset_acc");
        // Abort a partial tile while the count is below BEATS
        for (int k = 0; k < 2; k++) begin
            drive_beat(1'b0, 1'b1, unused_take);
            @(negedge clk);
            check_outputs(1'b0, 1'b0, 1'b0, held, "partial tile");
        end
        drive_beat(1'b0, 1'b1, unused_take);
        reset_acc = 1'b1;
        @(negedge clk);
        reset_acc = 1'b0;
        en        = 1'b0;
        check_outputs(1'b0, 1'b0, 1'b0, held, "after abort");
    endtask

    task automatic run_tile(input bit big);
        longint sums [CHUNK];
        chunk_t held;
        chunk_t expected;
        int     beats;
        int     sat_lanes;
        bit     took;
        held      = out_top;
        beats     = 0;
        sat_lanes = 0;
        for (int j = 0; j < CHUNK; j++) begin
            sums[j] = 0;
        end
        while (beats < BEATS) begin
            drive_beat(big, 1'b0, took);
            if (took) begin
                for (int j = 0; j < CHUNK; j++) begin
                    for (int c = 0; c < NUM_CORES; c++) begin
                        sums[j] += shifted_product(input_n[j], input_w[c][j]);
                    end
                end
                beats++;
            end
            @(negedge clk);
            check_outputs(1'b0, 1'b0, 1'b0, held, "during tile");
        end
        for (int j = 0; j < CHUNK; j++) begin
            expected[j] = clamp_word(sums[j]);
            if (sums[j] > 32767 || sums[j] < -32768) begin
                sat_lanes++;
            end
        end
        // Extra beats with en high must change nothing
        for (int k = 1; k <= POST_CYCLES; k++) begin
            drive_beat(big, 1'b1, took);
            @(negedge clk);
            check_outputs(1'b1, k >= 2, k == 3, (k >= 3) ? expected : held,
                          "after last beat");
        end
        en = 1'b0;
        if (big && sat_lanes == 0) begin
            errors++;
            $display("Large-operand tile at t=%0t did not push any lane out of range", $time);
        end
    endtask

    initial begin
        seed      = 32'hde38bd5b;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        en        = 1'b0;
        reset_acc = 1'b0;
        input_n   = '0;
        input_w   = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_outputs(1'b0, 1'b0, 1'b0, '0, "after reset");
        for (int t = 0; t < NUM_TILES; t++) begin
            if (t > 0) begin
                clear_tile();
            end
            run_tile(t % 3 == 2);
        end
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the tile count
    initial begin
        repeat (NUM_TILES * TILE_CYCLES + 100) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles",
                 NUM_TILES * TILE_CYCLES + 100);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
design/mm_pkg.sv
design/mac_lane.sv
design/dot_core.sv
design/reduce_buffer.sv
design/mm_top.sv
sim/tb_clock.sv
sim/mm_tb.sv

// File: Makefile
# Verilator build and run for the matrix-multiply tile

TOP := mm_tb

.PHONY: all lint clean

all:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir
